//--- logic/daq_cmd_pkg.sv
package daq_cmd_pkg;

  //////////////////////////////////////////////////////////////////////
  // Sizes
  //////////////////////////////////////////////////////////////////////
  localparam int cmd_width_c     = 16;
  localparam int cmd_depth_c     = 16;
  localparam int num_chn_c       = 64;
  localparam int chn_dac_width_c = 4;
  localparam int vth_width_c     = 10;
  localparam int cmd_ptr_width_c = $clog2(cmd_depth_c);
  localparam int cmd_cnt_width_c = $clog2(cmd_depth_c + 1);
  localparam int chn_idx_width_c = $clog2(num_chn_c);

  //////////////////////////////////////////////////////////////////////
  // Command encodings
  //////////////////////////////////////////////////////////////////////
  // Full-word opcodes
  localparam logic [cmd_width_c-1:0] op_acq_start     = 16'hF0F0;
  localparam logic [cmd_width_c-1:0] op_acq_stop      = 16'hF0F1;
  localparam logic [cmd_width_c-1:0] op_clr_data_fifo = 16'hF0FA;
  localparam logic [cmd_width_c-1:0] op_sc_mode       = 16'hA0A0;
  localparam logic [cmd_width_c-1:0] op_read_mode     = 16'hA0A1;
  localparam logic [cmd_width_c-1:0] op_param_load    = 16'hD0A2;
  localparam logic [cmd_width_c-1:0] op_mode_acq      = 16'hE0A0;
  localparam logic [cmd_width_c-1:0] op_mode_scurve   = 16'hE0A1;
  localparam logic [cmd_width_c-1:0] op_single_chn    = 16'hE0B0;
  localparam logic [cmd_width_c-1:0] op_all_chn       = 16'hE0B1;
  localparam logic [cmd_width_c-1:0] op_src_ctest     = 16'hE0C0;
  localparam logic [cmd_width_c-1:0] op_src_input     = 16'hE0C1;

  // Byte prefixes, argument in the low byte
  localparam logic [7:0] pfx_ctest    = 8'hA1;
  localparam logic [7:0] pfx_read_reg = 8'hA2;
  localparam logic [7:0] pfx_header   = 8'hAB;
  localparam logic [7:0] pfx_sw_gain  = 8'hB3;
  localparam logic [7:0] pfx_test_chn = 8'hE1;
  localparam logic [7:0] pfx_cpt_max  = 8'hE2;

  // ASIC number is A0Bx, tag sits in the argument high nibble
  localparam logic [7:0] pfx_asic_num   = 8'hA0;
  localparam logic [3:0] asic_num_tag_c = 4'hB;

  // Wide prefixes, 10-bit argument
  localparam logic [5:0] pfx_vth0    = 6'h30;
  localparam logic [5:0] pfx_vth1    = 6'h31;
  localparam logic [5:0] pfx_vth2    = 6'h32;
  localparam logic [5:0] pfx_chn_dac = 6'h33;

  localparam logic [15:0] cpt_max_default_c = 16'd10000;

  //////////////////////////////////////////////////////////////////////
  // Types
  //////////////////////////////////////////////////////////////////////
  typedef struct packed {
    logic [7:0] op;
    logic [7:0] arg;
  } cmd_byte_view_t;

  typedef struct packed {
    logic [5:0]             pfx;
    logic [vth_width_c-1:0] arg;
  } cmd_wide_view_t;

  // Same word, decoded either as byte pair or as prefix plus 10-bit field
  typedef union packed {
    cmd_byte_view_t byte_view;
    cmd_wide_view_t wide_view;
  } cmd_word_u;

  typedef struct packed {
    logic acq_on;
    logic clr_data_fifo;
    logic param_load;
  } acq_ctrl_t;

  typedef struct packed {
    logic                   sc_or_read;
    logic [2:0]             asic_num;
    logic [vth_width_c-1:0] vth0;
    logic [vth_width_c-1:0] vth1;
    logic [vth_width_c-1:0] vth2;
    logic [num_chn_c-1:0]   ctest;
    logic [num_chn_c-1:0]   read_reg;
    logic [7:0]             header;
    logic [1:0]             sw_hg;
    logic [1:0]             sw_lg;
  } asic_param_t;

  typedef struct packed {
    logic                       acq_or_sctest;
    logic                       single_or_all;
    logic                       ctest_or_input;
    logic [chn_idx_width_c-1:0] test_chn;
    logic [15:0]                cpt_max;
  } scurve_cfg_t;

endpackage

//--- logic/cmd_queue.sv
`timescale 1ns/10ps

module cmd_queue import daq_cmd_pkg::*; (
  input  logic                   clk,
  input  logic                   reset_n,
  input  logic                   cmd_wr,
  input  logic [cmd_width_c-1:0] cmd_data,
  output logic                   cmd_valid,
  output cmd_word_u              cmd
);

  logic [cmd_width_c-1:0]     mem [cmd_depth_c];
  logic [cmd_ptr_width_c-1:0] wr_ptr;
  logic [cmd_ptr_width_c-1:0] rd_ptr;
  logic [cmd_cnt_width_c-1:0] count;
  logic                       push;
  logic                       pop;

  // Words arriving on a full queue are lost
  assign push = cmd_wr && (count != cmd_cnt_width_c'(cmd_depth_c));

  // cmd_valid doubles as the popped-last-cycle flag
  assign pop = (count != '0) && !cmd_valid;

  //////////////////////////////////////////////////////////////////////
  // Storage and output word
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= cmd_data;
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      cmd <= mem[rd_ptr];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Pointers, fill level and strobe
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      cmd_valid <= 1'b0;
    end else begin
      cmd_valid <= pop;
      // Depth is a power of two, pointers wrap on their own
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

//--- logic/acq_ctrl_decoder.sv
`timescale 1ns/10ps

module acq_ctrl_decoder import daq_cmd_pkg::*; (
  input  logic      clk,
  input  logic      reset_n,
  input  logic      cmd_valid,
  input  cmd_word_u cmd,
  output acq_ctrl_t acq
);

  logic hit_start;
  logic hit_stop;
  logic hit_clr;
  logic hit_load;

  // Full-word matches, only meaningful with the strobe
  assign hit_start = cmd_valid && (cmd == op_acq_start);
  assign hit_stop  = cmd_valid && (cmd == op_acq_stop);
  assign hit_clr   = cmd_valid && (cmd == op_clr_data_fifo);
  assign hit_load  = cmd_valid && (cmd == op_param_load);

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      acq <= '0;
    end else begin
      // One-cycle pulses, dropped again on the next edge
      acq.clr_data_fifo <= hit_clr;
      acq.param_load    <= hit_load;

      // Acquisition level
      if (hit_start) begin
        acq.acq_on <= 1'b1;
      end else if (hit_stop) begin
        acq.acq_on <= 1'b0;
      end
    end
  end

endmodule

//--- logic/asic_param_decoder.sv
`timescale 1ns/10ps

module asic_param_decoder import daq_cmd_pkg::*; (
  input  logic        clk,
  input  logic        reset_n,
  input  logic        cmd_valid,
  input  cmd_word_u   cmd,
  output asic_param_t asic
);

  logic [7:0]             op;
  logic [7:0]             arg;
  logic [5:0]             wide_pfx;
  logic [vth_width_c-1:0] wide_arg;

  // Channel number 1..64 picks one bit, 255 optionally selects all
  function automatic logic [num_chn_c-1:0] chn_mask(
    input logic [7:0] sel,
    input logic       allow_all
  );
    logic [num_chn_c-1:0] mask;
    logic [7:0]           idx;
    mask = '0;
    idx  = sel - 8'd1;
    if (sel >= 8'd1 && sel <= 8'(num_chn_c)) begin
      mask[idx[chn_idx_width_c-1:0]] = 1'b1;
    end else if (allow_all && sel == 8'hFF) begin
      mask = '1;
    end
    return mask;
  endfunction

  assign op       = cmd.byte_view.op;
  assign arg      = cmd.byte_view.arg;
  assign wide_pfx = cmd.wide_view.pfx;
  assign wide_arg = cmd.wide_view.arg;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      asic.sc_or_read <= 1'b0;
      asic.asic_num   <= 3'd1;
      asic.vth0       <= 10'd1;
      asic.vth1       <= 10'd1;
      asic.vth2       <= 10'd1;
      asic.ctest      <= '0;
      asic.read_reg   <= '0;
      asic.header     <= 8'h55;
      asic.sw_hg      <= 2'b01;
      asic.sw_lg      <= 2'b01;
    end else if (cmd_valid) begin
      // Slow control or read register
      if (cmd == op_sc_mode) begin
        asic.sc_or_read <= 1'b0;
      end else if (cmd == op_read_mode) begin
        asic.sc_or_read <= 1'b1;
      end

      if (op == pfx_asic_num && arg[7:4] == asic_num_tag_c) begin
        asic.asic_num <= arg[2:0];
      end

      //////////////////////////////////////////////////////////////////
      // Thresholds, shifted out LSB first by the ASIC
      //////////////////////////////////////////////////////////////////
      case (wide_pfx)
        pfx_vth0: asic.vth0 <= {<<{wide_arg}};
        pfx_vth1: asic.vth1 <= {<<{wide_arg}};
        pfx_vth2: asic.vth2 <= {<<{wide_arg}};
        default:  ;
      endcase

      //////////////////////////////////////////////////////////////////
      // Byte commands
      //////////////////////////////////////////////////////////////////
      case (op)
        pfx_ctest: begin
          asic.ctest <= chn_mask(arg, 1'b1);
        end
        pfx_read_reg: begin
          asic.read_reg <= chn_mask(arg, 1'b0);
        end
        pfx_header: begin
          asic.header <= {<<{arg}};
        end
        pfx_sw_gain: begin
          // Bit 0 of each pair goes out first
          asic.sw_hg <= {arg[4], arg[5]};
          asic.sw_lg <= {arg[0], arg[1]};
        end
        default: ;
      endcase
    end
  end

endmodule

//--- logic/chn_dac_bank.sv
`timescale 1ns/10ps

module chn_dac_bank import daq_cmd_pkg::*; (
  input  logic                                 clk,
  input  logic                                 reset_n,
  input  logic                                 cmd_valid,
  input  cmd_word_u                            cmd,
  output logic [num_chn_c*chn_dac_width_c-1:0] chn_dac
);

  logic [chn_dac_width_c-1:0] dac_code [num_chn_c];
  logic                       wr_en;
  logic [chn_idx_width_c-1:0] wr_chn;
  logic [chn_dac_width_c-1:0] wr_code;

  // CC00..CFFF: channel in arg[9:4], code in arg[3:0]
  assign wr_en   = cmd_valid && (cmd.wide_view.pfx == pfx_chn_dac);
  assign wr_chn  = cmd.wide_view.arg[chn_dac_width_c +: chn_idx_width_c];
  assign wr_code = cmd.wide_view.arg[chn_dac_width_c-1:0];

  //////////////////////////////////////////////////////////////////////
  // Per-channel code store
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      for (int i = 0; i < num_chn_c; i++) begin
        dac_code[i] <= '0;
      end
    end else if (wr_en) begin
      dac_code[wr_chn] <= wr_code;
    end
  end

  // Flatten, channel 0 in the low nibble
  always_comb begin
    for (int i = 0; i < num_chn_c; i++) begin
      chn_dac[i*chn_dac_width_c +: chn_dac_width_c] = dac_code[i];
    end
  end

endmodule

//--- logic/scurve_decoder.sv
`timescale 1ns/10ps

module scurve_decoder import daq_cmd_pkg::*; (
  input  logic        clk,
  input  logic        reset_n,
  input  logic        cmd_valid,
  input  cmd_word_u   cmd,
  output scurve_cfg_t scurve
);

  // Max count table, unknown codes fall back to the default
  function automatic logic [15:0] cpt_max_lookup(input logic [7:0] code);
    case (code)
      8'd0:    return 16'd200;
      8'd1:    return 16'd1000;
      8'd2:    return 16'd2000;
      8'd3:    return 16'd5000;
      8'd4:    return 16'd10000;
      8'd5:    return 16'd20000;
      8'd6:    return 16'd40000;
      8'd7:    return 16'd50000;
      default: return cpt_max_default_c;
    endcase
  endfunction

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      scurve.acq_or_sctest  <= 1'b1;
      scurve.single_or_all  <= 1'b1;
      scurve.ctest_or_input <= 1'b1;
      scurve.test_chn       <= '0;
      scurve.cpt_max        <= cpt_max_default_c;
    end else if (cmd_valid) begin
      case (cmd)
        op_mode_acq:    scurve.acq_or_sctest  <= 1'b1;
        op_mode_scurve: scurve.acq_or_sctest  <= 1'b0;
        op_single_chn:  scurve.single_or_all  <= 1'b1;
        op_all_chn:     scurve.single_or_all  <= 1'b0;
        op_src_ctest:   scurve.ctest_or_input <= 1'b1;
        op_src_input:   scurve.ctest_or_input <= 1'b0;
        default: ;
      endcase

      // Channel only matters in single-channel mode
      if (cmd.byte_view.op == pfx_test_chn) begin
        scurve.test_chn <= cmd.byte_view.arg[chn_idx_width_c-1:0];
      end
      if (cmd.byte_view.op == pfx_cpt_max) begin
        scurve.cpt_max <= cpt_max_lookup(cmd.byte_view.arg);
      end
    end
  end

endmodule

//--- logic/cmd_interpreter_top.sv
`timescale 1ns/10ps

module cmd_interpreter_top import daq_cmd_pkg::*; (
  input  logic                                 clk,
  input  logic                                 reset_n,
  input  logic                                 cmd_wr,
  input  logic [cmd_width_c-1:0]               cmd_data,
  output acq_ctrl_t                            acq,
  output asic_param_t                          asic,
  output logic [num_chn_c*chn_dac_width_c-1:0] chn_dac,
  output scurve_cfg_t                          scurve
);

  // Broadcast from the queue to every decoder
  logic      cmd_valid;
  cmd_word_u cmd;

  //////////////////////////////////////////////////////////////////////
  // Command queue
  //////////////////////////////////////////////////////////////////////
  cmd_queue cmd_queue_inst (
    .clk       (clk),
    .reset_n   (reset_n),
    .cmd_wr    (cmd_wr),
    .cmd_data  (cmd_data),
    .cmd_valid (cmd_valid),
    .cmd       (cmd)
  );

  //////////////////////////////////////////////////////////////////////
  // Decoders, each ignores opcodes it does not own
  //////////////////////////////////////////////////////////////////////
  acq_ctrl_decoder acq_ctrl_decoder_inst (
    .clk       (clk),
    .reset_n   (reset_n),
    .cmd_valid (cmd_valid),
    .cmd       (cmd),
    .acq       (acq)
  );

  asic_param_decoder asic_param_decoder_inst (
    .clk       (clk),
    .reset_n   (reset_n),
    .cmd_valid (cmd_valid),
    .cmd       (cmd),
    .asic      (asic)
  );

  chn_dac_bank chn_dac_bank_inst (
    .clk       (clk),
    .reset_n   (reset_n),
    .cmd_valid (cmd_valid),
    .cmd       (cmd),
    .chn_dac   (chn_dac)
  );

  scurve_decoder scurve_decoder_inst (
    .clk       (clk),
    .reset_n   (reset_n),
    .cmd_valid (cmd_valid),
    .cmd       (cmd),
    .scurve    (scurve)
  );

endmodule

//--- verif/tb_cmd_interpreter.sv
`timescale 1ns/10ps

module tb_cmd_interpreter import daq_cmd_pkg::*; ();

  // Limit is several times the roughly 340 cycles the tests take
  localparam int timeout_cycles_c = 3000;

  logic                                 clk;
  logic                                 reset_n;
  logic                                 cmd_wr;
  logic [cmd_width_c-1:0]               cmd_data;
  acq_ctrl_t                            acq;
  asic_param_t                          asic;
  logic [num_chn_c*chn_dac_width_c-1:0] chn_dac;
  scurve_cfg_t                          scurve;

  int seed = 39107;
  int cycles = 0;
  int tests_run = 0;
  int checks = 0;
  int errors = 0;
  int test_errors = 0;
  int clr_seen = 0;
  int load_seen = 0;

  cmd_interpreter_top cmd_interpreter_top_inst (
    .clk      (clk),
    .reset_n  (reset_n),
    .cmd_wr   (cmd_wr),
    .cmd_data (cmd_data),
    .acq      (acq),
    .asic     (asic),
    .chn_dac  (chn_dac),
    .scurve   (scurve)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles >= timeout_cycles_c) begin
      $display("Timeout after %0d cycles, the tests did not complete", cycles);
      $display("TEST FAIL");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////
  task automatic check_value(input string test_name, input string what,
                             input logic [255:0] expected, input logic [255:0] actual);
    checks++;
    assert (actual === expected) else begin
      $display("FAIL %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
      errors++;
      test_errors++;
    end
  endtask

  task automatic send_cmd(input logic [cmd_width_c-1:0] word);
    @(posedge clk);
    cmd_wr   <= 1'b1;
    cmd_data <= word;
  endtask

  // Two cycles per queued word plus four of slack
  // Pulses are counted while the queue drains
  task automatic wait_drain(input int words);
    @(posedge clk);
    cmd_wr <= 1'b0;
    repeat (2 * words + 4) begin
      @(negedge clk);
      if (acq.clr_data_fifo) begin
        clr_seen++;
      end
      if (acq.param_load) begin
        load_seen++;
      end
    end
  endtask

  task automatic apply_cmd(input logic [cmd_width_c-1:0] word);
    send_cmd(word);
    wait_drain(1);
  endtask

  task automatic finish_test(input string test_name);
    tests_run++;
    if (test_errors == 0) begin
      $display("test %s: ok", test_name);
    end else begin
      $display("test %s: %0d errors", test_name, test_errors);
    end
    test_errors = 0;
  endtask

  // Mirror the low width bits
  function automatic logic [9:0] reverse_bits(input logic [9:0] value, input int width);
    logic [9:0] result;
    result = '0;
    for (int i = 0; i < width; i++) begin
      result[i] = value[width-1-i];
    end
    return result;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////////////////////////
  task automatic test_reset_values();
    check_value("reset_values", "acq", 3'b000, acq);
    check_value("reset_values", "asic_num", 3'd1, asic.asic_num);
    check_value("reset_values", "vth0", 10'd1, asic.vth0);
    check_value("reset_values", "vth1", 10'd1, asic.vth1);
    check_value("reset_values", "vth2", 10'd1, asic.vth2);
    check_value("reset_values", "ctest", 64'h0, asic.ctest);
    check_value("reset_values", "read_reg", 64'h0, asic.read_reg);
    check_value("reset_values", "header", 8'h55, asic.header);
    check_value("reset_values", "sw_hg", 2'b01, asic.sw_hg);
    check_value("reset_values", "sw_lg", 2'b01, asic.sw_lg);
    check_value("reset_values", "chn_dac", 256'h0, chn_dac);
    check_value("reset_values", "acq_or_sctest", 1'b1, scurve.acq_or_sctest);
    check_value("reset_values", "single_or_all", 1'b1, scurve.single_or_all);
    check_value("reset_values", "ctest_or_input", 1'b1, scurve.ctest_or_input);
    check_value("reset_values", "test_chn", 6'd0, scurve.test_chn);
    check_value("reset_values", "cpt_max", 16'd10000, scurve.cpt_max);
    finish_test("reset_values");
  endtask

  task automatic test_acq_ctrl();
    apply_cmd(op_acq_start);
    check_value("acq_ctrl", "acq_on after start", 1'b1, acq.acq_on);
    apply_cmd(op_acq_stop);
    check_value("acq_ctrl", "acq_on after stop", 1'b0, acq.acq_on);
    clr_seen  = 0;
    load_seen = 0;
    apply_cmd(op_clr_data_fifo);
    check_value("acq_ctrl", "clr_data_fifo cycles", 1, clr_seen);
    check_value("acq_ctrl", "param_load cycles on clear", 0, load_seen);
    clr_seen  = 0;
    load_seen = 0;
    apply_cmd(op_param_load);
    check_value("acq_ctrl", "param_load cycles", 1, load_seen);
    check_value("acq_ctrl", "clr_data_fifo cycles on load", 0, clr_seen);
    finish_test("acq_ctrl");
  endtask

  task automatic test_thresholds_header();
    logic [31:0] r;
    logic [9:0]  vth [3];
    logic [7:0]  hdr;
    logic [7:0]  gain;
    logic [2:0]  num;
    for (int i = 0; i < 3; i++) begin
      r      = $random(seed);
      vth[i] = r[9:0];
    end
    r    = $random(seed);
    hdr  = r[7:0];
    num  = r[10:8];
    gain = r[23:16];
    // Keep away from the reset value
    if (num == 3'd1) begin
      num = 3'd6;
    end
    apply_cmd({pfx_vth0, vth[0]});
    apply_cmd({pfx_vth1, vth[1]});
    apply_cmd({pfx_vth2, vth[2]});
    apply_cmd({pfx_header, hdr});
    apply_cmd({pfx_asic_num, asic_num_tag_c, 1'b0, num});
    apply_cmd({pfx_sw_gain, gain});
    check_value("thresholds_header", "vth0", reverse_bits(vth[0], 10), asic.vth0);
    check_value("thresholds_header", "vth1", reverse_bits(vth[1], 10), asic.vth1);
    check_value("thresholds_header", "vth2", reverse_bits(vth[2], 10), asic.vth2);
    check_value("thresholds_header", "header", reverse_bits({2'b00, hdr}, 8), asic.header);
    check_value("thresholds_header", "asic_num", num, asic.asic_num);
    check_value("thresholds_header", "sw_hg", reverse_bits({8'h00, gain[5:4]}, 2),
                asic.sw_hg);
    check_value("thresholds_header", "sw_lg", reverse_bits({8'h00, gain[1:0]}, 2),
                asic.sw_lg);
    apply_cmd(op_read_mode);
    check_value("thresholds_header", "sc_or_read read", 1'b1, asic.sc_or_read);
    apply_cmd(op_sc_mode);
    check_value("thresholds_header", "sc_or_read sc", 1'b0, asic.sc_or_read);
    finish_test("thresholds_header");
  endtask

  task automatic test_masks();
    apply_cmd({pfx_ctest, 8'd0});
    check_value("masks", "ctest 0", 64'h0, asic.ctest);
    apply_cmd({pfx_ctest, 8'd1});
    check_value("masks", "ctest 1", 64'h1, asic.ctest);
    apply_cmd({pfx_ctest, 8'd64});
    check_value("masks", "ctest 64", 64'h8000_0000_0000_0000, asic.ctest);
    apply_cmd({pfx_ctest, 8'd255});
    check_value("masks", "ctest 255", {64{1'b1}}, asic.ctest);
    apply_cmd({pfx_ctest, 8'd100});
    check_value("masks", "ctest 100", 64'h0, asic.ctest);
    // Set one bit first so the 255 case has to clear it
    apply_cmd({pfx_read_reg, 8'd5});
    check_value("masks", "read_reg 5", 64'h10, asic.read_reg);
    apply_cmd({pfx_read_reg, 8'd255});
    check_value("masks", "read_reg 255", 64'h0, asic.read_reg);
    finish_test("masks");
  endtask

  task automatic test_chn_dac_bank();
    logic [31:0]  r;
    logic [5:0]   chn [16];
    logic [3:0]   code;
    logic [255:0] model;
    model = '0;
    for (int i = 0; i < 16; i++) begin
      r = $random(seed);
      // Last four writes revisit earlier channels
      chn[i] = (i < 12) ? r[5:0] : chn[i-12];
      code   = r[11:8];
      model[chn[i]*4 +: 4] = code;
      send_cmd({pfx_chn_dac, chn[i], code});
    end
    wait_drain(16);
    check_value("chn_dac_bank", "chn_dac", model, chn_dac);
    finish_test("chn_dac_bank");
  endtask

  task automatic test_scurve();
    logic [31:0] r;
    logic [5:0]  chn;
    logic [15:0] cpt_table [8];
    cpt_table = '{16'd200, 16'd1000, 16'd2000, 16'd5000,
                  16'd10000, 16'd20000, 16'd40000, 16'd50000};
    apply_cmd(op_mode_scurve);
    check_value("scurve", "acq_or_sctest", 1'b0, scurve.acq_or_sctest);
    apply_cmd(op_all_chn);
    check_value("scurve", "single_or_all", 1'b0, scurve.single_or_all);
    apply_cmd(op_src_input);
    check_value("scurve", "ctest_or_input", 1'b0, scurve.ctest_or_input);
    apply_cmd(op_mode_acq);
    check_value("scurve", "acq_or_sctest back", 1'b1, scurve.acq_or_sctest);
    apply_cmd(op_single_chn);
    check_value("scurve", "single_or_all back", 1'b1, scurve.single_or_all);
    apply_cmd(op_src_ctest);
    check_value("scurve", "ctest_or_input back", 1'b1, scurve.ctest_or_input);
    r   = $random(seed);
    chn = r[5:0];
    // Channel 0 is the reset value
    if (chn == 6'd0) begin
      chn = 6'd33;
    end
    apply_cmd({pfx_test_chn, 2'b00, chn});
    check_value("scurve", "test_chn", chn, scurve.test_chn);
    for (int code = 0; code < 8; code++) begin
      apply_cmd({pfx_cpt_max, 8'(code)});
      check_value("scurve", "cpt_max", cpt_table[code], scurve.cpt_max);
    end
    apply_cmd({pfx_cpt_max, 8'd9});
    check_value("scurve", "cpt_max code 9", 16'd10000, scurve.cpt_max);
    finish_test("scurve");
  endtask

  //////////////////////////////////////////////////////////////////////
  // Sequence
  //////////////////////////////////////////////////////////////////////
  initial begin
    clk      = 1'b0;
    reset_n  = 1'b0;
    cmd_wr   = 1'b0;
    cmd_data = '0;
    repeat (2) @(posedge clk);
    reset_n <= 1'b1;
    @(negedge clk);
    test_reset_values();
    test_acq_ctrl();
    test_thresholds_header();
    test_masks();
    test_chn_dac_bank();
    test_scurve();
    $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

//--- sim.f
logic/daq_cmd_pkg.sv
logic/cmd_queue.sv
logic/acq_ctrl_decoder.sv
logic/asic_param_decoder.sv
logic/chn_dac_bank.sv
logic/scurve_decoder.sv
logic/cmd_interpreter_top.sv
verif/tb_cmd_interpreter.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_cmd_interpreter
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'TEST PASS'

clean:
	rm -rf $(OBJ_DIR)
